/* source/vec_pkg.sv */
/*
 * Shared definitions of the vector accelerator:
 * vector sizes, element and register-index types,
 * the opcode enumeration and the instruction struct
 */

package vec_pkg;

  //////////////////////////////
  // Vector sizes
  //////////////////////////////

  localparam int unsigned VecElems  = 8;
  localparam int unsigned NrVRegs   = 8;
  localparam int unsigned ElemWidth = 16;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [ElemWidth-1:0] elem_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;

  typedef enum logic [1:0] {
    VEC_VMV     = 2'd0,
    VEC_VADD    = 2'd1,
    VEC_VREDSUM = 2'd2
  } vec_op_e;

  // One vector instruction, 27 bits
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } vec_req_t;

endpackage : vec_pkg

/* source/vec_pe_if.sv */
/*
 * Bus between the sequencer, the lanes and the reduction unit,
 * with one modport per side
 */

interface vec_pe_if import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) ();

  // Instruction broadcast
  vec_req_t                  req;
  logic                      req_valid;

  // Per-lane completion and partial sums
  logic     [NrLanes-1:0]    lane_done;
  elem_t    [NrLanes-1:0]    partial;
  logic     [NrLanes-1:0]    partial_valid;

  // Scalar from the reduction unit
  elem_t                     red_result;
  logic                      red_valid;

  modport sequencer (output req, req_valid, input lane_done, red_result, red_valid);
  modport lane (input req, req_valid, output lane_done, partial, partial_valid);
  modport reduce (input req_valid, partial, partial_valid, output red_result, red_valid);

endinterface : vec_pe_if

/* source/vec_dispatcher.sv */
/*
 * Host side of the accelerator: request acceptance,
 * forwarding to the sequencer, response buffer with back-pressure
 */

module vec_dispatcher import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Host request
  input  vec_op_e   acc_req_op_i,
  input  vreg_idx_t acc_req_vd_i,
  input  vreg_idx_t acc_req_vs1_i,
  input  vreg_idx_t acc_req_vs2_i,
  input  elem_t     acc_req_scalar_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  // Host response
  output elem_t     acc_resp_result_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i,
  // Sequencer
  output vec_req_t  issue_req_o,
  output logic      issue_valid_o,
  input  logic      issue_ready_i,
  input  logic      done_i,
  input  elem_t     done_result_i
);

  logic  busy_q;
  logic  resp_valid_q;
  elem_t resp_result_q;
  logic  req_fire;
  logic  resp_fire;

  // Host fields go straight through to the sequencer
  always_comb begin
    issue_req_o.op     = acc_req_op_i;
    issue_req_o.vd     = acc_req_vd_i;
    issue_req_o.vs1    = acc_req_vs1_i;
    issue_req_o.vs2    = acc_req_vs2_i;
    issue_req_o.scalar = acc_req_scalar_i;
  end

  assign issue_valid_o   = acc_req_valid_i & ~busy_q;
  assign acc_req_ready_o = ~busy_q & issue_ready_i;
  assign req_fire        = acc_req_valid_i & acc_req_ready_o;
  assign resp_fire       = resp_valid_q & acc_resp_ready_i;

  // Busy from acceptance until the host takes the response
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q       <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      if (req_fire) begin
        busy_q <= 1'b1;
      end else if (resp_fire) begin
        busy_q <= 1'b0;
      end
      if (done_i) begin
        resp_valid_q <= 1'b1;
      end else if (resp_fire) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  // Result held until accepted
  always_ff @(posedge clk_i) begin
    if (done_i) begin
      resp_result_q <= done_result_i;
    end
  end

  assign acc_resp_valid_o  = resp_valid_q;
  assign acc_resp_result_o = resp_result_q;

endmodule : vec_dispatcher

/* source/vec_sequencer.sv */
/*
 * Instruction issue to the lanes and completion tracking.
 * One instruction in flight at a time
 */

module vec_sequencer import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Dispatcher
  input  vec_req_t issue_req_i,
  input  logic     issue_valid_i,
  output logic     issue_ready_o,
  output logic     done_o,
  output elem_t    done_result_o,
  // Processing elements
  vec_pe_if.sequencer pe
);

  vec_req_t             req_q;
  logic                 req_valid_q;
  logic                 busy_q;
  logic [NrLanes-1:0]   seen_q;
  logic                 all_lanes_done;
  logic                 finish;
  logic                 done_q;
  elem_t                done_result_q;

  assign issue_ready_o = ~busy_q;

  // Lanes that finished so far, this cycle included
  assign all_lanes_done = &(seen_q | pe.lane_done);
  // Reductions also wait for the scalar
  assign finish = busy_q & all_lanes_done & ((req_q.op != VEC_VREDSUM) | pe.red_valid);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      req_valid_q <= 1'b0;
      seen_q      <= '0;
      done_q      <= 1'b0;
    end else begin
      req_valid_q <= issue_valid_i & issue_ready_o;
      done_q      <= finish;
      if (issue_valid_i && issue_ready_o) begin
        busy_q <= 1'b1;
        seen_q <= '0;
      end else if (finish) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        seen_q <= seen_q | pe.lane_done;
      end
    end
  end

  // Instruction and result payload
  always_ff @(posedge clk_i) begin
    if (issue_valid_i && issue_ready_o) begin
      req_q <= issue_req_i;
    end
    if (finish) begin
      done_result_q <= (req_q.op == VEC_VREDSUM) ? pe.red_result : '0;
    end
  end

  assign pe.req        = req_q;
  assign pe.req_valid  = req_valid_q;
  assign done_o        = done_q;
  assign done_result_o = done_result_q;

endmodule : vec_sequencer

/* source/vec_lane.sv */
/*
 * One vector lane: slice of the register file,
 * element ALU and the partial sum for reductions
 */

module vec_lane import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned LaneId  = 0
) (
  input  logic clk_i,
  input  logic rst_n_i,
  vec_pe_if.lane pe
);

  localparam int unsigned ElemsPerLane = VecElems / NrLanes;
  localparam int unsigned CntWidth     = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1;

  //////////////////////////////
  // Register file slice
  //////////////////////////////

  // Local slot i holds global element i*NrLanes + LaneId
  elem_t vrf_q [NrVRegs-1:0][ElemsPerLane-1:0];

  vec_req_t              insn_q;
  logic                  active_q;
  logic [CntWidth-1:0]   cnt_q;
  logic                  last_elem;
  logic                  done_q;
  logic                  pvalid_q;
  elem_t                 acc_q;
  elem_t                 op_a;
  elem_t                 op_b;
  elem_t                 wr_data;

  assign op_a      = vrf_q[insn_q.vs1][cnt_q];
  assign op_b      = vrf_q[insn_q.vs2][cnt_q];
  assign last_elem = (cnt_q == CntWidth'(ElemsPerLane - 1));

  // Element ALU, sums wrap at ElemWidth
  always_comb begin
    case (insn_q.op)
      VEC_VMV: wr_data = insn_q.scalar;
      default: wr_data = op_a + op_b;
    endcase
  end

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
      done_q   <= 1'b0;
      pvalid_q <= 1'b0;
    end else begin
      done_q   <= 1'b0;
      pvalid_q <= 1'b0;
      if (pe.req_valid) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (active_q) begin
        cnt_q <= cnt_q + CntWidth'(1);
        if (last_elem) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
          pvalid_q <= (insn_q.op == VEC_VREDSUM);
        end
      end
    end
  end

  // Instruction latch and partial sum
  always_ff @(posedge clk_i) begin
    if (pe.req_valid) begin
      insn_q <= pe.req;
      acc_q  <= '0;
    end else if (active_q && insn_q.op == VEC_VREDSUM) begin
      acc_q <= acc_q + op_a;
    end
  end

  // Write back, one element per cycle
  always_ff @(posedge clk_i) begin
    if (active_q && insn_q.op != VEC_VREDSUM) begin
      vrf_q[insn_q.vd][cnt_q] <= wr_data;
    end
  end

  assign pe.lane_done[LaneId]     = done_q;
  assign pe.partial_valid[LaneId] = pvalid_q;
  assign pe.partial[LaneId]       = acc_q;

endmodule : vec_lane

/* source/vec_reduce.sv */
/*
 * Reduction unit: adds the lane partial sums
 * and returns the scalar result to the sequencer
 */

module vec_reduce import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  vec_pe_if.reduce pe
);

  logic [NrLanes-1:0] arrived_q;
  logic [NrLanes-1:0] arrived_d;
  elem_t              sum_q;
  elem_t              sum_d;
  elem_t              result_q;
  logic               red_valid_q;
  logic               complete;

  // Fold in every partial that shows up this cycle
  always_comb begin
    sum_d = sum_q;
    for (int l = 0; l < NrLanes; l++) begin
      if (pe.partial_valid[l]) begin
        sum_d = sum_d + pe.partial[l];
      end
    end
  end

  assign arrived_d = arrived_q | pe.partial_valid;
  // Last lane arrives
  assign complete  = (|pe.partial_valid) & (&arrived_d);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      arrived_q   <= '0;
      red_valid_q <= 1'b0;
    end else begin
      red_valid_q <= complete;
      arrived_q   <= pe.req_valid ? '0 : arrived_d;
    end
  end

  always_ff @(posedge clk_i) begin
    sum_q <= pe.req_valid ? '0 : sum_d;
    if (complete) begin
      result_q <= sum_d;
    end
  end

  assign pe.red_result = result_q;
  assign pe.red_valid  = red_valid_q;

endmodule : vec_reduce

/* source/vec_unit.sv */
/*
 * Top level of the vector accelerator: dispatcher,
 * sequencer, NrLanes lanes and the reduction unit
 */

module vec_unit import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Host request
  input  vec_op_e   acc_req_op_i,
  input  vreg_idx_t acc_req_vd_i,
  input  vreg_idx_t acc_req_vs1_i,
  input  vreg_idx_t acc_req_vs2_i,
  input  elem_t     acc_req_scalar_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  // Host response
  output elem_t     acc_resp_result_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i
);

  vec_req_t issue_req;
  logic     issue_valid;
  logic     issue_ready;
  logic     done;
  elem_t    done_result;

  vec_pe_if #(.NrLanes(NrLanes)) pe_bus ();

  //////////////////////////////
  // Dispatcher and sequencer
  //////////////////////////////

  vec_dispatcher i_dispatcher (
    .clk_i            (clk_i            ),
    .rst_n_i          (rst_n_i          ),
    .acc_req_op_i     (acc_req_op_i     ),
    .acc_req_vd_i     (acc_req_vd_i     ),
    .acc_req_vs1_i    (acc_req_vs1_i    ),
    .acc_req_vs2_i    (acc_req_vs2_i    ),
    .acc_req_scalar_i (acc_req_scalar_i ),
    .acc_req_valid_i  (acc_req_valid_i  ),
    .acc_req_ready_o  (acc_req_ready_o  ),
    .acc_resp_result_o(acc_resp_result_o),
    .acc_resp_valid_o (acc_resp_valid_o ),
    .acc_resp_ready_i (acc_resp_ready_i ),
    .issue_req_o      (issue_req        ),
    .issue_valid_o    (issue_valid      ),
    .issue_ready_i    (issue_ready      ),
    .done_i           (done             ),
    .done_result_i    (done_result      )
  );

  vec_sequencer #(.NrLanes(NrLanes)) i_sequencer (
    .clk_i        (clk_i           ),
    .rst_n_i      (rst_n_i         ),
    .issue_req_i  (issue_req       ),
    .issue_valid_i(issue_valid     ),
    .issue_ready_o(issue_ready     ),
    .done_o       (done            ),
    .done_result_o(done_result     ),
    .pe           (pe_bus.sequencer)
  );

  //////////////////////////////
  // Lanes and reduction
  //////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes(NrLanes),
      .LaneId (l      )
    ) i_lane (
      .clk_i  (clk_i      ),
      .rst_n_i(rst_n_i    ),
      .pe     (pe_bus.lane)
    );
  end : gen_lanes

  vec_reduce #(.NrLanes(NrLanes)) i_reduce (
    .clk_i  (clk_i        ),
    .rst_n_i(rst_n_i      ),
    .pe     (pe_bus.reduce)
  );

endmodule : vec_unit

/* sim/tb_clock.sv */
/*
 * Free-running testbench clock
 */

module tb_clock #(
  parameter int unsigned Period = 8
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(Period / 2) clk_o = ~clk_o;

endmodule : tb_clock

/* sim/vec_unit_props.sv */
/*
 * Concurrent checks on the host handshakes of the accelerator,
 * bound into the top level
 */

module vec_unit_props import vec_pkg::*; (
  input logic  clk_i,
  input logic  rst_n_i,
  input logic  acc_req_valid_i,
  input logic  acc_req_ready_o,
  input elem_t acc_resp_result_o,
  input logic  acc_resp_valid_o,
  input logic  acc_resp_ready_i
);

  // Accepted request still waiting for its response
  logic req_open_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_open_q <= 1'b0;
    end else if (acc_req_valid_i && acc_req_ready_o) begin
      req_open_q <= 1'b1;
    end else if (acc_resp_valid_o && acc_resp_ready_i) begin
      req_open_q <= 1'b0;
    end
  end

  resp_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_result_o))
    else $error("response dropped or changed under back-pressure");

  no_req_during_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o |-> !acc_req_ready_o)
    else $error("request ready while a response is pending");

  resp_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(acc_resp_valid_o) |-> req_open_q)
    else $error("response raised without an accepted request");

endmodule : vec_unit_props

bind vec_unit vec_unit_props i_props (
  .clk_i            (clk_i            ),
  .rst_n_i          (rst_n_i          ),
  .acc_req_valid_i  (acc_req_valid_i  ),
  .acc_req_ready_o  (acc_req_ready_o  ),
  .acc_resp_result_o(acc_resp_result_o),
  .acc_resp_valid_o (acc_resp_valid_o ),
  .acc_resp_ready_i (acc_resp_ready_i )
);

/* sim/vec_unit_tb.sv */
/*
 * Testbench of the vector accelerator: LFSR stimulus,
 * register file model, compare tasks and the closing report
 */

module vec_unit_tb import vec_pkg::*; ();

  localparam int unsigned NrLanes    = 4;
  localparam int unsigned DriveDelay = 1;
  localparam int unsigned WaitLimit  = 200;

  logic      clk_i;
  logic      rst_n_i;
  vec_op_e   acc_req_op_i;
  vreg_idx_t acc_req_vd_i;
  vreg_idx_t acc_req_vs1_i;
  vreg_idx_t acc_req_vs2_i;
  elem_t     acc_req_scalar_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  elem_t     acc_resp_result_o;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;

  logic [15:0] lfsr_q = 16'd58683;
  elem_t       model_vrf [NrVRegs][VecElems];
  int unsigned check_count = 0;
  int unsigned error_count = 0;
  logic        timed_out = 1'b0;

  tb_clock #(.Period(8)) i_clock (.clk_o(clk_i));

  vec_unit #(.NrLanes(NrLanes)) uut (.*);

  //////////////////////////////
  // Stimulus and model
  //////////////////////////////

  // Taps 16, 14, 13, 11
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // Returns the expected response and updates the model register file
  function automatic elem_t predict_and_update(input vec_op_e op, input vreg_idx_t vd,
                                               input vreg_idx_t vs1, input vreg_idx_t vs2,
                                               input elem_t scalar);
    elem_t sum;
    elem_t next [VecElems];
    sum = '0;
    for (int e = 0; e < VecElems; e++) begin
      case (op)
        VEC_VMV:  next[e] = scalar;
        VEC_VADD: next[e] = model_vrf[vs1][e] + model_vrf[vs2][e];
        default:  sum = sum + model_vrf[vs1][e];
      endcase
    end
    if (op != VEC_VREDSUM) begin
      for (int e = 0; e < VecElems; e++) begin
        model_vrf[vd][e] = next[e];
      end
    end
    return sum;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_result(input string name, input elem_t actual, input elem_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR at %0t: %s = 0x%04h, expected 0x%04h", $time, name, actual, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR at %0t: %s = %b, expected %b", $time, name, actual, expected);
    end
  endtask

  //////////////////////////////
  // Host handshakes
  //////////////////////////////

  task automatic send_request(input vec_op_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
                              input vreg_idx_t vs2, input elem_t scalar);
    int unsigned tries;
    tries            = 0;
    acc_req_op_i     = op;
    acc_req_vd_i     = vd;
    acc_req_vs1_i    = vs1;
    acc_req_vs2_i    = vs2;
    acc_req_scalar_i = scalar;
    acc_req_valid_i  = 1'b1;
    while (!acc_req_ready_o && tries < WaitLimit) begin
      @(posedge clk_i);
      #DriveDelay;
      tries++;
    end
    if (!acc_req_ready_o) begin
      timed_out = 1'b1;
      $display("Timeout at %0t: the DUT never accepted the request", $time);
    end else begin
      @(posedge clk_i);
      #DriveDelay;
    end
    acc_req_valid_i = 1'b0;
  endtask

  // Holds ready low for hold cycles once the response is up
  task automatic take_response(input elem_t expected, input int unsigned hold);
    int unsigned tries;
    tries = 0;
    while (!acc_resp_valid_o && tries < WaitLimit) begin
      @(posedge clk_i);
      #DriveDelay;
      tries++;
    end
    if (!acc_resp_valid_o) begin
      timed_out = 1'b1;
      $display("Timeout at %0t: no response arrived for the request", $time);
      return;
    end
    for (int unsigned c = 0; c < hold; c++) begin
      @(posedge clk_i);
      #DriveDelay;
      check_flag("acc_resp_valid_o", acc_resp_valid_o, 1'b1);
      check_flag("acc_req_ready_o", acc_req_ready_o, 1'b0);
      check_result("acc_resp_result_o", acc_resp_result_o, expected);
    end
    check_result("acc_resp_result_o", acc_resp_result_o, expected);
    acc_resp_ready_i = 1'b1;
    @(posedge clk_i);
    #DriveDelay;
    acc_resp_ready_i = 1'b0;
    check_flag("acc_resp_valid_o", acc_resp_valid_o, 1'b0);
    check_flag("acc_req_ready_o", acc_req_ready_o, 1'b1);
  endtask

  task automatic run_op(input vec_op_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
                        input vreg_idx_t vs2, input elem_t scalar, input int unsigned hold);
    elem_t expected;
    if (timed_out) begin
      return;
    end
    expected = predict_and_update(op, vd, vs1, vs2, scalar);
    send_request(op, vd, vs1, vs2, scalar);
    if (!timed_out) begin
      take_response(expected, hold);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timed_out);
    if (error_count == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    rst_n_i          = 1'b0;
    acc_req_op_i     = VEC_VMV;
    acc_req_vd_i     = '0;
    acc_req_vs1_i    = '0;
    acc_req_vs2_i    = '0;
    acc_req_scalar_i = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #DriveDelay;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #DriveDelay;
    check_flag("acc_resp_valid_o", acc_resp_valid_o, 1'b0);
    check_flag("acc_req_ready_o", acc_req_ready_o, 1'b1);

    // Splat every register, then reduce each one
    for (int r = 0; r < NrVRegs; r++) begin
      run_op(VEC_VMV, vreg_idx_t'(r), '0, '0, elem_t'(rand_bits(16)), 0);
    end
    for (int r = 0; r < NrVRegs; r++) begin
      run_op(VEC_VREDSUM, '0, vreg_idx_t'(r), '0, '0, 0);
    end

    // Element-wise adds with some in place
    for (int i = 0; i < 12; i++) begin
      vd  = vreg_idx_t'(rand_bits(3));
      vs1 = (i % 3 == 0) ? vd : vreg_idx_t'(rand_bits(3));
      run_op(VEC_VADD, vd, vs1, vreg_idx_t'(rand_bits(3)), '0, 0);
      run_op(VEC_VREDSUM, '0, vd, '0, '0, 0);
    end

    // Long back-pressure on the response
    for (int i = 0; i < 4; i++) begin
      run_op(VEC_VREDSUM, '0, vreg_idx_t'(rand_bits(3)), '0, '0, 4 + rand_bits(4));
      run_op(VEC_VMV, vreg_idx_t'(rand_bits(3)), '0, '0, elem_t'(rand_bits(16)),
             4 + rand_bits(4));
    end

    // Mixed random traffic
    for (int i = 0; i < 200; i++) begin
      case (rand_bits(2) % 3)
        0:       op = VEC_VMV;
        1:       op = VEC_VADD;
        default: op = VEC_VREDSUM;
      endcase
      run_op(op, vreg_idx_t'(rand_bits(3)), vreg_idx_t'(rand_bits(3)),
             vreg_idx_t'(rand_bits(3)), elem_t'(rand_bits(16)), rand_bits(2));
    end

    finish_run();
  end

endmodule : vec_unit_tb

/* vec_unit.f */
source/vec_pkg.sv
source/vec_pe_if.sv
source/vec_dispatcher.sv
source/vec_sequencer.sv
source/vec_lane.sv
source/vec_reduce.sv
source/vec_unit.sv
sim/tb_clock.sv
sim/vec_unit_props.sv
sim/vec_unit_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := vec_unit_tb
FILELIST  := vec_unit.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL TESTS PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
